// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SRAM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_sram_subsystem -Mdir obj_dir -f sram_subsystem.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_sram_subsystem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

// ==== sim/tb_sram_subsystem.sv ====
`default_nettype none

module tb_sram_subsystem import sram_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 256;

    logic        clk_i;
    logic        arst_n_i;
    wb_req_t     wb_i;
    logic        wb_en_i;
    logic        wb_ack_o;
    logic [31:0] wb_dat_o;
    logic        core_req_i;
    obi_req_t    core_cmd_i;
    logic        core_gnt_o;
    logic        core_rvalid_o;
    logic [31:0] core_rdata_o;
    logic        illegal_o;

    // Shadow of the RAM contents
    logic [31:0] shadow [WORDS];
    logic        exp_illegal;

    // Pending responses with bit 32 set for a read
    logic [32:0] core_exp_q[$];
    logic [32:0] host_exp_q[$];

    string  test_name;
    int     tests, checks, errors, errs_at_start, host_acks;
    integer seed;

    sram_subsystem i_sram_subsystem (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] ref_access(input logic [31:0] addr, input logic we,
                                               input logic [3:0] be, input logic [31:0] wdata,
                                               input logic from_host);
        logic [31:0] a;
        logic [31:0] off;
        int          idx;

        a = addr;
        // Host range folds onto the RAM window
        if (from_host && addr >= HOST_REMAP_LO && addr < HOST_REMAP_HI) begin
            a = {4'h8, addr[27:0]};
        end
        off = a - RAM_BASE;
        if (a < RAM_BASE || off >= 32'(4 * WORDS)) begin
            exp_illegal = 1'b1;
            return 32'h0;
        end
        idx = int'(off[31:2]);
        if (!we) begin
            return shadow[idx];
        end
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                shadow[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return 32'h0;
    endfunction

    ////////////////////////////////////////
    // Checks and bookkeeping
    ////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_read(input string what, input logic [32:0] exp, input logic [31:0] act);
        if (exp[32]) begin
            check_value(what, exp[31:0], act);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errs_at_start) begin
            $display("Test %s passed", test_name);
        end else begin
            $display("Test %s failed with %0d errors", test_name, errors - errs_at_start);
        end
    endtask

    // Oldest pending expectation per port
    always @(negedge clk_i) begin
        if (core_rvalid_o) begin
            if (core_exp_q.size() == 0) begin
                $display("Core response arrived with nothing outstanding in %s", test_name);
                errors++;
            end else begin
                check_read("core read data", core_exp_q.pop_front(), core_rdata_o);
            end
        end
        if (wb_ack_o) begin
            host_acks++;
            if (host_exp_q.size() == 0) begin
                $display("Wishbone ack arrived with nothing outstanding in %s", test_name);
                errors++;
            end else begin
                check_read("host read data", host_exp_q.pop_front(), wb_dat_o);
            end
        end
    end

    ////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////

    task automatic core_transfer(input logic [31:0] addr, input logic we, input logic [3:0] be,
                                 input logic [31:0] wdata);
        int          n;
        logic [31:0] exp;
        logic        granted;

        core_req_i = 1'b1;
        core_cmd_i = {addr, we, be, wdata};
        n = 0;
        @(negedge clk_i);
        while (!core_gnt_o && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        granted = core_gnt_o;
        if (!granted) begin
            $display("Timeout: core request to %h never granted in %s", addr, test_name);
            errors++;
        end
        // Accepting edge
        @(posedge clk_i);
        if (granted) begin
            exp = ref_access(addr, we, be, wdata, 1'b0);
            core_exp_q.push_back({!we, exp});
        end
        #2;
        core_req_i = 1'b0;
        @(negedge clk_i);
        if (granted) begin
            check_value("core_rvalid_o one cycle after accept", 32'h1, 32'(core_rvalid_o));
        end
        @(posedge clk_i);
        #2;
    endtask

    task automatic wb_transfer(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                               input logic [31:0] dat);
        int          n;
        logic [31:0] exp;

        // Host wins any tie so its effect comes first
        exp = ref_access(adr, we, sel, dat, 1'b1);
        host_exp_q.push_back({!we, exp});
        wb_i = {1'b1, 1'b1, we, sel, adr, dat};
        n = 0;
        @(negedge clk_i);
        while (!wb_ack_o && n < 50) begin
            @(negedge clk_i);
            n++;
        end
        if (!wb_ack_o) begin
            $display("Timeout: no Wishbone ack for address %h in %s", adr, test_name);
            errors++;
            void'(host_exp_q.pop_back());
        end
        @(posedge clk_i);
        #2;
        check_value("wb_ack_o after one cycle", 32'h0, 32'(wb_ack_o));
        wb_i = '0;
    endtask

    task automatic core_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        core_transfer(addr, 1'b1, be, wdata);
    endtask

    task automatic core_read(input logic [31:0] addr);
        core_transfer(addr, 1'b0, 4'hf, 32'h0);
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [3:0] sel, input logic [31:0] dat);
        wb_transfer(adr, 1'b1, sel, dat);
    endtask

    task automatic wb_read(input logic [31:0] adr);
        wb_transfer(adr, 1'b0, 4'hf, 32'h0);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] a;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [3:0]  nib;
        int          acks_before;

        seed        = 32'h8afa8f28;
        exp_illegal = 1'b0;
        arst_n_i    = 1'b0;
        wb_i        = '0;
        wb_en_i     = 1'b1;
        core_req_i  = 1'b0;
        core_cmd_i  = '0;
        repeat (3) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;

        start_test("reset");
        check_value("outputs after reset", 32'h0,
                    32'({wb_ack_o, core_gnt_o, core_rvalid_o, illegal_o}));
        end_test();

        start_test("fill");
        for (int i = 0; i < WORDS; i++) begin
            a = RAM_BASE + 32'(4 * i);
            core_write(a, 4'hf, a * 32'h9e37_79b9 ^ 32'h5a5a_5a5a);
        end
        end_test();

        start_test("core_byte_enable");
        core_write(RAM_BASE + 32'h20, 4'b0101, 32'hdead_beef);
        core_read(RAM_BASE + 32'h20);
        end_test();

        start_test("host_remap");
        wb_write(32'h3000_0040, 4'hf, 32'h1234_5678);
        core_read(32'h8000_0040);
        wb_read(32'h3000_0040);
        end_test();

        start_test("host_enable");
        wb_en_i     = 1'b0;
        acks_before = host_acks;
        fork
            wb_read(32'h3000_0040);
            begin
                core_write(RAM_BASE + 32'h80, 4'hf, 32'h0bad_cafe);
                core_read(RAM_BASE + 32'h80);
                repeat (20) @(posedge clk_i);
                check_value("host acks while disabled", 32'(acks_before), 32'(host_acks));
                #2;
                wb_en_i = 1'b1;
            end
        join
        end_test();

        start_test("host_priority");
        fork
            wb_write(32'h3000_0100, 4'hf, 32'hc0de_0001);
            core_read(32'h8000_0100);
        join
        end_test();

        start_test("random_mix");
        for (int i = 0; i < 200; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            if (r1[8]) begin
                // Remapped nibbles 3 to 6 or the window itself
                nib = r1[9] ? 4'h8 : 4'h3 + {2'b0, r1[16:15]};
                a   = {nib, 18'b0, r1[7:0], 2'b00};
                if (r1[10]) begin
                    wb_write(a, r1[14:11], r2);
                end else begin
                    wb_read(a);
                end
            end else begin
                a = RAM_BASE | {22'b0, r1[7:0], 2'b00};
                if (r1[10]) begin
                    core_write(a, r1[14:11], r2);
                end else begin
                    core_read(a);
                end
            end
        end
        check_value("illegal_o after in-window traffic", 32'(exp_illegal), 32'(illegal_o));
        end_test();

        start_test("out_of_window");
        core_read(RAM_BASE + 32'(4 * WORDS));
        check_value("illegal_o after bad read", 32'(exp_illegal), 32'(illegal_o));
        core_write(RAM_BASE + 32'(4 * WORDS) + 32'h4, 4'hf, 32'hffff_ffff);
        wb_write(HOST_REMAP_LO + 32'(4 * WORDS), 4'hf, 32'heeee_eeee);
        wb_write(32'h9000_0004, 4'hf, 32'hdddd_dddd);
        // Aliased words stay untouched
        core_read(RAM_BASE + 32'h4);
        core_read(RAM_BASE);
        check_value("illegal_o sticky", 32'(exp_illegal), 32'(illegal_o));
        end_test();

        if (core_exp_q.size() != 0 || host_exp_q.size() != 0) begin
            $display("Some responses never arrived before the end of the run");
            errors++;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sram_subsystem.f ====
verilog/sram_pkg.sv
verilog/wb_obi_bridge.sv
verilog/port_arbiter.sv
verilog/ff_ram.sv
verilog/sram_subsystem.sv
sim/tb_sram_subsystem.sv

// ==== verilog/ff_ram.sv ====
`default_nettype none

module ff_ram import sram_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic        clk_i,
    input  logic        arst_n_i,

    input  logic        req_i,
    input  obi_req_t    cmd_i,
    output logic        rvalid_o,
    output logic [31:0] rdata_o,

    // Sticky until reset
    output logic        illegal_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [31:0]   offset;
    logic          in_window;
    logic [AW-1:0] word_idx;

    ////////////////////////////////////////
    // Window check
    ////////////////////////////////////////

    assign offset    = cmd_i.addr - RAM_BASE;
    assign in_window = (cmd_i.addr >= RAM_BASE) && (offset < 32'(4 * RAM_WORDS));
    assign word_idx  = offset[AW+1:2];

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Byte lanes written at the accepting edge
    always_ff @(posedge clk_i) begin
        if (req_i && cmd_i.we && in_window) begin
            for (int b = 0; b < 4; b++) begin
                if (cmd_i.be[b]) begin
                    mem[word_idx][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read that returns zero for writes and illegal accesses
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (in_window && !cmd_i.we) begin
                rdata_o <= mem[word_idx];
            end else begin
                rdata_o <= '0;
            end
        end
    end

    ////////////////////////////////////////
    // Control flops
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_o  <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            rvalid_o <= req_i;
            if (req_i && !in_window) begin
                illegal_o <= 1'b1;
            end
        end
    end

    // One outstanding access means no request overlaps its response
    rvalid_after_req: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rvalid_o |-> ($past(req_i) && !req_i)
    );

endmodule

`default_nettype wire

// ==== verilog/port_arbiter.sv ====
`default_nettype none

module port_arbiter import sram_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Host port with fixed priority
    input  logic        host_req_i,
    input  obi_req_t    host_cmd_i,
    output logic        host_gnt_o,
    output logic        host_rvalid_o,
    output logic [31:0] host_rdata_o,

    // Core data port
    input  logic        core_req_i,
    input  obi_req_t    core_cmd_i,
    output logic        core_gnt_o,
    output logic        core_rvalid_o,
    output logic [31:0] core_rdata_o,

    // Shared RAM
    output logic        ram_req_o,
    output obi_req_t    ram_cmd_o,
    input  logic        ram_rvalid_i,
    input  logic [31:0] ram_rdata_i
);

    arb_state_e state_q, state_d;

    ////////////////////////////////////////
    // Grant and command select
    ////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        host_gnt_o = 1'b0;
        core_gnt_o = 1'b0;
        ram_req_o  = 1'b0;
        ram_cmd_o  = core_cmd_i;

        unique case (state_q)
            ARB_IDLE: begin
                if (host_req_i) begin
                    host_gnt_o = 1'b1;
                    ram_req_o  = 1'b1;
                    ram_cmd_o  = host_cmd_i;
                    state_d    = ARB_HOST;
                end else if (core_req_i) begin
                    core_gnt_o = 1'b1;
                    ram_req_o  = 1'b1;
                    state_d    = ARB_CORE;
                end
            end
            // Owner waits for its response with no new grants
            ARB_HOST, ARB_CORE: begin
                if (ram_rvalid_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////
    // Response routing
    ////////////////////////////////////////

    // The busy state remembers who owns the response
    assign host_rvalid_o = ram_rvalid_i && (state_q == ARB_HOST);
    assign core_rvalid_o = ram_rvalid_i && (state_q == ARB_CORE);

    assign host_rdata_o = ram_rdata_i;
    assign core_rdata_o = ram_rdata_i;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    one_grant: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(host_gnt_o && core_gnt_o)
    );

    // RAM must never answer a request the arbiter did not issue
    no_orphan_rvalid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ram_rvalid_i |-> (state_q != ARB_IDLE)
    );

endmodule

`default_nettype wire

// ==== verilog/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    ////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////

    // Address phase of an OBI-style request
    typedef struct packed {
        logic [31:0] addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } obi_req_t;

    // Wishbone classic slave inputs from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    localparam logic [31:0] RAM_BASE      = 32'h8000_0000;

    // Host addresses in [LO, HI) get the top nibble replaced
    localparam logic [31:0] HOST_REMAP_LO = 32'h3000_0000;
    localparam logic [31:0] HOST_REMAP_HI = 32'h8000_0000;

    ////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////

    typedef enum logic [1:0] {ARB_IDLE, ARB_HOST, ARB_CORE} arb_state_e;

    typedef enum logic [1:0] {BR_IDLE, BR_WAIT, BR_ACK} bridge_state_e;

endpackage

`default_nettype wire

// ==== verilog/sram_subsystem.sv ====
`default_nettype none

module sram_subsystem import sram_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Host Wishbone port
    input  wb_req_t     wb_i,
    input  logic        wb_en_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,

    // Core data port
    input  logic        core_req_i,
    input  obi_req_t    core_cmd_i,
    output logic        core_gnt_o,
    output logic        core_rvalid_o,
    output logic [31:0] core_rdata_o,

    output logic        illegal_o
);

    // Bridge to arbiter
    logic        host_req, host_gnt, host_rvalid;
    obi_req_t    host_cmd;
    logic [31:0] host_rdata;

    // Arbiter to RAM
    logic        ram_req, ram_rvalid;
    obi_req_t    ram_cmd;
    logic [31:0] ram_rdata;

    wb_obi_bridge i_wb_obi_bridge (
        .clk_i,
        .arst_n_i,
        .wb_i,
        .wb_en_i,
        .wb_ack_o,
        .wb_dat_o,
        .host_req_o    (host_req),
        .host_cmd_o    (host_cmd),
        .host_gnt_i    (host_gnt),
        .host_rvalid_i (host_rvalid),
        .host_rdata_i  (host_rdata)
    );

    port_arbiter i_port_arbiter (
        .clk_i,
        .arst_n_i,
        .host_req_i    (host_req),
        .host_cmd_i    (host_cmd),
        .host_gnt_o    (host_gnt),
        .host_rvalid_o (host_rvalid),
        .host_rdata_o  (host_rdata),
        .core_req_i,
        .core_cmd_i,
        .core_gnt_o,
        .core_rvalid_o,
        .core_rdata_o,
        .ram_req_o     (ram_req),
        .ram_cmd_o     (ram_cmd),
        .ram_rvalid_i  (ram_rvalid),
        .ram_rdata_i   (ram_rdata)
    );

    ff_ram #(.RAM_WORDS(RAM_WORDS)) i_ff_ram (
        .clk_i,
        .arst_n_i,
        .req_i     (ram_req),
        .cmd_i     (ram_cmd),
        .rvalid_o  (ram_rvalid),
        .rdata_o   (ram_rdata),
        .illegal_o
    );

endmodule

`default_nettype wire

// ==== verilog/wb_obi_bridge.sv ====
`default_nettype none

module wb_obi_bridge import sram_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Wishbone classic slave
    input  wb_req_t     wb_i,
    input  logic        wb_en_i,
    output logic        wb_ack_o,
    output logic [31:0] wb_dat_o,

    // Request side towards the arbiter
    output logic        host_req_o,
    output obi_req_t    host_cmd_o,
    input  logic        host_gnt_i,
    input  logic        host_rvalid_i,
    input  logic [31:0] host_rdata_i
);

    bridge_state_e state_q, state_d;
    logic [31:0]   rdata_q;
    logic [31:0]   remap_addr;
    logic          wb_active;

    assign wb_active = wb_i.cyc && wb_i.stb;

    ////////////////////////////////////////
    // Address remap and command
    ////////////////////////////////////////

    always_comb begin
        remap_addr = wb_i.adr;
        // Host window folds onto the RAM window
        if (wb_i.adr >= HOST_REMAP_LO && wb_i.adr < HOST_REMAP_HI) begin
            remap_addr = {HOST_REMAP_HI[31:28], wb_i.adr[27:0]};
        end
    end

    always_comb begin
        host_cmd_o.addr  = remap_addr;
        host_cmd_o.we    = wb_i.we;
        host_cmd_o.be    = wb_i.sel;
        host_cmd_o.wdata = wb_i.dat;
    end

    ////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////

    // Host enable only holds off new requests
    assign host_req_o = (state_q == BR_IDLE) && wb_active && wb_en_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            BR_IDLE: begin
                if (host_req_o && host_gnt_i) begin
                    state_d = BR_WAIT;
                end
            end
            BR_WAIT: begin
                if (host_rvalid_i) begin
                    state_d = BR_ACK;
                end
            end
            BR_ACK: state_d = BR_IDLE;
            default: state_d = BR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Read data held for the ack cycle
    always_ff @(posedge clk_i) begin
        if (state_q == BR_WAIT && host_rvalid_i) begin
            rdata_q <= host_rdata_i;
        end
    end

    assign wb_ack_o = (state_q == BR_ACK);
    assign wb_dat_o = rdata_q;

    // Host must keep the cycle open until acked
    ack_inside_cycle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_o |-> wb_active
    );

endmodule

`default_nettype wire
